//--- common/rv_defs.svh
/*
  rv32i core widths, register count, reset vector and ecall encoding
*/
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define RV_XLEN 32

// register index width and count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// ecall, full instruction word
`define RV_INST_ECALL 32'h0000_0073

`endif

//--- common/rv_pkg.sv
/*
  rv32i core types: major opcodes, alu operations,
  branch conditions and controller states
*/
package rv_pkg;

  // major opcodes, rv32i encodings
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // same values as the branch funct3 field
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  typedef enum logic [2:0] {
    st_fetch_req, st_fetch_wait, st_execute,
    st_mem_req, st_mem_wait, st_halted
  } core_state_e;

endpackage

//--- core/rv_alu.sv
/*
  rv32i alu: ten integer operations plus branch compare
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::alu_op_e     alu_op,
  input  logic [`RV_XLEN-1:0] cmp_b,
  input  rv_pkg::br_cond_e    br_cond,
  output logic [`RV_XLEN-1:0] result,
  output logic                taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {31'b0, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = a + b;
    endcase
  end

  // branch compare, rs1 against rs2
  assign eq   = (a == cmp_b);
  assign lt_s = ($signed(a) < $signed(cmp_b));
  assign lt_u = (a < cmp_b);

  always_comb begin
    case (br_cond)
      rv_pkg::br_eq:  taken = eq;
      rv_pkg::br_ne:  taken = !eq;
      rv_pkg::br_lt:  taken = lt_s;
      rv_pkg::br_ge:  taken = !lt_s;
      rv_pkg::br_ltu: taken = lt_u;
      rv_pkg::br_geu: taken = !lt_u;
      // funct3 010 and 011 are not branches
      default:        taken = 1'b0;
    endcase
  end

endmodule

//--- core/rv_core_ctrl.sv
/*
  core controller with the multi-cycle FSM, pc and instruction registers,
  four-phase memory bus handshake and register write-back select
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  bus_ack,
  input  logic [`RV_XLEN-1:0]   bus_rdata,
  input  rv_pkg::opcode_e       opcode,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic                  is_ecall,
  input  logic [`RV_XLEN-1:0]   alu_result,
  input  logic                  taken,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  output logic [`RV_XLEN-1:0]   inst,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  rf_we,
  output logic [`RV_XLEN-1:0]   rf_wdata,
  output logic                  bus_req,
  output logic                  bus_we,
  output logic [`RV_XLEN-1:0]   bus_addr,
  output logic [`RV_XLEN-1:0]   bus_wdata,
  output logic                  halt
);

  rv_pkg::core_state_e state;

  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_imm;
  logic [`RV_XLEN-1:0] next_pc;
  logic                is_load;
  logic                is_store;
  logic                wb_exec;
  logic                fetch_done;

  assign is_load  = (opcode == rv_pkg::opc_load);
  assign is_store = (opcode == rv_pkg::opc_store);

  assign pc_plus4 = pc + 32'd4;
  // shared by taken branches and jal
  assign pc_imm   = pc + imm;

  always_comb begin
    case (opcode)
      rv_pkg::opc_branch: next_pc = taken ? pc_imm : pc_plus4;
      rv_pkg::opc_jal:    next_pc = pc_imm;
      rv_pkg::opc_jalr:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:            next_pc = pc_plus4;
    endcase
  end

  // opcodes that write rd at the end of execute
  always_comb begin
    case (opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc, rv_pkg::opc_jal, rv_pkg::opc_jalr,
      rv_pkg::opc_op, rv_pkg::opc_op_imm: wb_exec = 1'b1;
      default:                            wb_exec = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      rv_pkg::opc_lui:  rf_wdata = imm;
      rv_pkg::opc_jal,
      rv_pkg::opc_jalr: rf_wdata = pc_plus4;
      rv_pkg::opc_load: rf_wdata = bus_rdata;
      default:          rf_wdata = alu_result;
    endcase
  end

  // load data is written on the edge where ack is seen high
  assign rf_we = (rd != '0) &&
                 ((state == rv_pkg::st_execute && wb_exec) ||
                  (state == rv_pkg::st_mem_req && bus_ack && is_load));

  assign fetch_done = (state == rv_pkg::st_fetch_req) && bus_req && bus_ack;

  assign halt = (state == rv_pkg::st_halted);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= rv_pkg::st_fetch_req;
      pc      <= `RV_RESET_PC;
      bus_req <= 1'b0;
      bus_we  <= 1'b0;
    end else begin
      case (state)
        rv_pkg::st_fetch_req: begin
          if (!bus_req && !bus_ack) begin
            bus_req <= 1'b1;
            bus_we  <= 1'b0;
          end else if (fetch_done) begin
            bus_req <= 1'b0;
            state   <= rv_pkg::st_fetch_wait;
          end
        end
        rv_pkg::st_fetch_wait: begin
          if (!bus_ack) begin
            state <= rv_pkg::st_execute;
          end
        end
        rv_pkg::st_execute: begin
          if (is_ecall) begin
            state <= rv_pkg::st_halted;
          end else if (is_load || is_store) begin
            // ack is already low here so the data request goes out at once
            bus_req <= 1'b1;
            bus_we  <= is_store;
            state   <= rv_pkg::st_mem_req;
          end else begin
            pc    <= next_pc;
            state <= rv_pkg::st_fetch_req;
          end
        end
        rv_pkg::st_mem_req: begin
          if (bus_ack) begin
            bus_req <= 1'b0;
            bus_we  <= 1'b0;
            state   <= rv_pkg::st_mem_wait;
          end
        end
        rv_pkg::st_mem_wait: begin
          if (!bus_ack) begin
            pc    <= pc_plus4;
            state <= rv_pkg::st_fetch_req;
          end
        end
        rv_pkg::st_halted: state <= rv_pkg::st_halted;
        default:           state <= rv_pkg::st_fetch_req;
      endcase
    end
  end

  // instruction word and bus payload
  always_ff @(posedge clk) begin
    if (fetch_done) begin
      inst <= bus_rdata;
    end
    if (state == rv_pkg::st_fetch_req && !bus_req) begin
      bus_addr <= pc;
    end else if (state == rv_pkg::st_execute && (is_load || is_store)) begin
      bus_addr  <= alu_result;
      bus_wdata <= rs2_data;
    end
  end

endmodule

//--- core/rv_decoder.sv
/*
  rv32i decoder: instruction fields, sign-extended immediate and
  alu / branch operation select
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0]   inst,
  output rv_pkg::opcode_e       opcode,
  output logic [`RV_REG_AW-1:0] rd,
  output logic [`RV_REG_AW-1:0] rs1,
  output logic [`RV_REG_AW-1:0] rs2,
  output logic [`RV_XLEN-1:0]   imm,
  output rv_pkg::alu_op_e       alu_op,
  output logic                  use_imm,
  output rv_pkg::br_cond_e      br_cond,
  output logic                  is_ecall
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    case (opcode)
      rv_pkg::opc_store:  imm = imm_s;
      rv_pkg::opc_branch: imm = imm_b;
      rv_pkg::opc_jal:    imm = imm_j;
      rv_pkg::opc_lui,
      rv_pkg::opc_auipc:  imm = imm_u;
      default:            imm = imm_i;
    endcase
  end

  // loads, stores, jalr and auipc fall through to add
  always_comb begin
    alu_op = rv_pkg::alu_add;
    if (opcode == rv_pkg::opc_op || opcode == rv_pkg::opc_op_imm) begin
      case (funct3)
        3'b000: begin
          // sub only exists in register form
          if (opcode == rv_pkg::opc_op && funct7[5]) begin
            alu_op = rv_pkg::alu_sub;
          end else begin
            alu_op = rv_pkg::alu_add;
          end
        end
        3'b001: alu_op = rv_pkg::alu_sll;
        3'b010: alu_op = rv_pkg::alu_slt;
        3'b011: alu_op = rv_pkg::alu_sltu;
        3'b100: alu_op = rv_pkg::alu_xor;
        3'b101: begin
          if (funct7[5]) begin
            alu_op = rv_pkg::alu_sra;
          end else begin
            alu_op = rv_pkg::alu_srl;
          end
        end
        3'b110: alu_op = rv_pkg::alu_or;
        default: alu_op = rv_pkg::alu_and;
      endcase
    end
  end

  // branches compare against rs2 on a separate path
  assign use_imm = (opcode != rv_pkg::opc_op);

  assign br_cond = rv_pkg::br_cond_e'(funct3);

  assign is_ecall = (inst == `RV_INST_ECALL);

endmodule

//--- core/rv_reg_file.sv
/*
  integer register file, two read ports and one write port, x0 hardwired to zero
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic                  we,
  input  logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // combinational reads
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

//--- design/rv_core_top.sv
/*
  rv32i multi-cycle core top, decoder, alu, register file and
  controller on one req/ack memory bus
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst,
  output logic                bus_req,
  output logic                bus_we,
  output logic [`RV_XLEN-1:0] bus_addr,
  output logic [`RV_XLEN-1:0] bus_wdata,
  input  logic                bus_ack,
  input  logic [`RV_XLEN-1:0] bus_rdata,
  output logic                halt
);

  rv_pkg::opcode_e       opcode;
  rv_pkg::alu_op_e       alu_op;
  rv_pkg::br_cond_e      br_cond;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   inst;
  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   alu_a;
  logic [`RV_XLEN-1:0]   alu_b;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   rf_wdata;
  logic                  use_imm;
  logic                  is_ecall;
  logic                  taken;
  logic                  rf_we;

  // auipc adds to the pc, everything else to rs1
  assign alu_a = (opcode == rv_pkg::opc_auipc) ? pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  rv_decoder decoder_i (
    .inst(inst), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
    .alu_op(alu_op), .use_imm(use_imm), .br_cond(br_cond), .is_ecall(is_ecall)
  );

  rv_alu alu_i (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .cmp_b(rs2_data), .br_cond(br_cond),
    .result(alu_result), .taken(taken)
  );

  rv_reg_file reg_file_i (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rf_we),
    .wdata(rf_wdata), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_core_ctrl ctrl_i (
    .clk(clk), .rst(rst), .bus_ack(bus_ack), .bus_rdata(bus_rdata),
    .opcode(opcode), .rd(rd), .imm(imm), .is_ecall(is_ecall),
    .alu_result(alu_result), .taken(taken), .rs2_data(rs2_data),
    .inst(inst), .pc(pc), .rf_we(rf_we), .rf_wdata(rf_wdata),
    .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .halt(halt)
  );

endmodule

//--- project.f
+incdir+common
+incdir+testbench
common/rv_pkg.sv
core/rv_decoder.sv
core/rv_alu.sv
core/rv_reg_file.sv
core/rv_core_ctrl.sv
design/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build the rv32i core testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_rv_core \
  -f project.f -o sim_rv_core &&
./obj_dir/sim_rv_core || { echo "simulation failed"; exit 1; }

//--- testbench/tb_ref_model.svh
/*
  core testbench model: galois lfsr, random program generator
  and instruction-set level reference executor
*/
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'hdad9_ed54;

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return r;
endfunction

function automatic void emit(logic [31:0] w);
  prog_mem[prog_len] = w;
  prog_len++;
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic void build_program();
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [2:0]  kind;
  logic [6:0]  f7;
  logic [11:0] imm;
  for (int i = 0; i < MEM_WORDS; i++) begin
    prog_mem[i] = i * 32'h9e37_79b9 ^ 32'h0f1e_2d3c;
  end
  prog_len = 0;
  // x31 holds the data base 0x1000 for the whole program
  emit({20'h00001, 5'd31, rv_pkg::opc_lui});
  emit({20'h12345, 5'd1, rv_pkg::opc_auipc});
  // jal over one word, that word would set x3
  emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd2, rv_pkg::opc_jal});
  emit(enc_i(12'h7ff, 5'd0, 3'b000, 5'd3, rv_pkg::opc_op_imm));
  emit({20'h00000, 5'd4, rv_pkg::opc_auipc});
  // odd offset, bit 0 of the target is dropped
  emit(enc_i(12'd13, 5'd4, 3'b000, 5'd5, rv_pkg::opc_jalr));
  emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd6, rv_pkg::opc_op_imm));
  emit({20'hfedcb, 5'd7, rv_pkg::opc_lui});
  for (int i = 0; i < BODY_LEN; i++) begin
    kind = 3'(rand_bits(3));
    rd   = 5'(rand_bits(5));
    rs1  = 5'(rand_bits(5));
    rs2  = 5'(rand_bits(5));
    f3   = 3'(rand_bits(3));
    imm  = 12'(rand_bits(12));
    // x31 keeps the base, so these writes go to x0
    if (rd == 5'd31) rd = 5'd0;
    if (kind == 3'd7 && i + 4 < BODY_LEN) begin
      // forward branch, skips zero to three words
      if (f3 == 3'b010 || f3 == 3'b011) f3 = f3 + 3'd2;
      imm = 12'(4 * (rand_bits(2) + 1));
      emit({1'b0, imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch});
    end else if (kind == 3'd6) begin
      emit(enc_s({2'b00, imm[7:0], 2'b00}, rs2, 5'd31, 3'b010, rv_pkg::opc_store));
    end else if (kind == 3'd5) begin
      emit(enc_i({2'b00, imm[7:0], 2'b00}, 5'd31, 3'b010, rd, rv_pkg::opc_load));
    end else if (kind >= 3'd3) begin
      if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
      if (f3 == 3'b101) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
      emit(enc_i(imm, rs1, f3, rd, rv_pkg::opc_op_imm));
    end else begin
      f7 = ((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'h20 : 7'h00;
      emit({f7, rs2, rs1, f3, rd, rv_pkg::opc_op});
    end
  end
  // every register to the upper data words
  for (int r = 0; r < 32; r++) begin
    emit(enc_s(12'(1024 + 4 * r), 5'(r), 5'd31, 3'b010, rv_pkg::opc_store));
  end
  emit(`RV_INST_ECALL);
  for (int i = 0; i < 4096; i++) begin
    ack_delay[i] = 2'(rand_bits(2));
  end
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $unsigned($signed(a) >>> b[4:0]);
      end else begin
        return a >> b[4:0];
      end
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic void expect_access(logic we, logic [31:0] addr, logic [31:0] data);
  exp_we.push_back(we);
  exp_addr.push_back(addr);
  exp_data.push_back(data);
endfunction

// runs the program and lists every bus access in order
function automatic void run_reference();
  logic [31:0] rmem [MEM_WORDS];
  logic [31:0] x [32];
  logic [31:0] pc;
  logic [31:0] npc;
  logic [31:0] inst;
  logic [31:0] addr;
  logic [31:0] tgt;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic        done;
  int          steps;
  rmem = prog_mem;
  for (int i = 0; i < 32; i++) begin
    x[i] = '0;
  end
  pc    = `RV_RESET_PC;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 100000) begin
    inst = rmem[pc[12:2]];
    expect_access(1'b0, pc, 32'h0);
    rd    = inst[11:7];
    rs1   = inst[19:15];
    rs2   = inst[24:20];
    f3    = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    npc   = pc + 32'd4;
    case (inst[6:0])
      rv_pkg::opc_lui:   x[rd] = {inst[31:12], 12'h000};
      rv_pkg::opc_auipc: x[rd] = pc + {inst[31:12], 12'h000};
      rv_pkg::opc_jal: begin
        x[rd] = npc;
        npc   = pc + imm_j;
      end
      rv_pkg::opc_jalr: begin
        tgt   = (x[rs1] + imm_i) & ~32'd1;
        x[rd] = npc;
        npc   = tgt;
      end
      rv_pkg::opc_branch: begin
        if (branch_ref(f3, x[rs1], x[rs2])) npc = pc + imm_b;
      end
      rv_pkg::opc_load: begin
        addr = x[rs1] + imm_i;
        expect_access(1'b0, addr, 32'h0);
        x[rd] = rmem[addr[12:2]];
      end
      rv_pkg::opc_store: begin
        addr = x[rs1] + imm_s;
        expect_access(1'b1, addr, x[rs2]);
        rmem[addr[12:2]] = x[rs2];
      end
      rv_pkg::opc_op_imm: x[rd] = alu_ref(f3, f3 == 3'b101 && inst[30], x[rs1], imm_i);
      rv_pkg::opc_op:     x[rd] = alu_ref(f3, inst[30], x[rs1], x[rs2]);
      // unknown opcodes fall through as no-ops
      default: done = (inst == `RV_INST_ECALL);
    endcase
    x[0] = '0;
    pc   = npc;
    steps++;
  end
endfunction

`endif

//--- testbench/tb_rv_core.sv
/*
  rv32i core testbench: memory with random ack delay, bus access
  compare against the reference model, bus hold and halt checks
*/
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

  localparam int MEM_WORDS    = 2048;
  localparam int BODY_LEN     = 160;
  localparam int HALT_TIMEOUT = 40000;

  logic                clk = 1'b0;
  logic                rst = 1'b1;
  logic                bus_req;
  logic                bus_we;
  logic [`RV_XLEN-1:0] bus_addr;
  logic [`RV_XLEN-1:0] bus_wdata;
  logic                bus_ack = 1'b0;
  logic [`RV_XLEN-1:0] bus_rdata = '0;
  logic                halt;

  // program image, memory model, ack delays and expected accesses
  logic [31:0] prog_mem [MEM_WORDS];
  logic [31:0] mem [MEM_WORDS];
  logic [1:0]  ack_delay [4096];
  logic        exp_we [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          prog_len;
  int          access_idx = 0;

  logic        busy = 1'b0;
  logic [1:0]  delay_left = '0;
  logic [11:0] delay_idx = '0;

  logic        hold_prev = 1'b0;
  logic        we_prev;
  logic [31:0] addr_prev;
  logic [31:0] wdata_prev;

  `include "tb_ref_model.svh"

  rv_core_top dut_i (
    .clk(clk), .rst(rst), .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_ack(bus_ack), .bus_rdata(bus_rdata), .halt(halt)
  );

  always #20 clk = ~clk;

  task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // memory responder, ack after 0 to 3 cycles
  always @(posedge clk) begin
    if (rst) begin
      mem = prog_mem;
      busy = 1'b0;
      bus_ack <= 1'b0;
    end else if (bus_req && !bus_ack) begin
      if (!busy) begin
        busy = 1'b1;
        delay_left = ack_delay[delay_idx];
        delay_idx = delay_idx + 12'd1;
      end
      if (delay_left == 2'd0) begin
        busy = 1'b0;
        bus_ack <= 1'b1;
        if (bus_we) begin
          mem[bus_addr[12:2]] = bus_wdata;
        end else begin
          bus_rdata <= mem[bus_addr[12:2]];
        end
      end else begin
        delay_left = delay_left - 2'd1;
      end
    end else if (!bus_req && bus_ack) begin
      bus_ack <= 1'b0;
    end
  end

  // an access completes on the edge where the core sees ack
  always @(posedge clk) begin
    if (!rst && bus_req && bus_ack) begin
      if (access_idx >= exp_addr.size()) begin
        $display("bus access to %h beyond the end of the reference flow", bus_addr);
        $display(">>> FAIL");
        $fatal(1, "unexpected bus access");
      end else begin
        check_equal($sformatf("access %0d we", access_idx),
                    32'(exp_we[access_idx]), 32'(bus_we));
        check_equal($sformatf("access %0d addr", access_idx), exp_addr[access_idx], bus_addr);
        if (exp_we[access_idx]) begin
          check_equal($sformatf("access %0d store data", access_idx),
                      exp_data[access_idx], bus_wdata);
        end
        access_idx <= access_idx + 1;
      end
    end
  end

  // request payload frozen while waiting for ack
  always @(posedge clk) begin
    if (!rst && hold_prev) begin
      check_equal("hold req", 32'd1, 32'(bus_req));
      check_equal("hold we", 32'(we_prev), 32'(bus_we));
      check_equal("hold addr", addr_prev, bus_addr);
      check_equal("hold wdata", wdata_prev, bus_wdata);
    end
    hold_prev  <= bus_req && !bus_ack;
    we_prev    <= bus_we;
    addr_prev  <= bus_addr;
    wdata_prev <= bus_wdata;
  end

  initial begin
    int cycles;
    build_program();
    run_reference();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_equal("req after reset", 32'd0, 32'(bus_req));
    check_equal("halt after reset", 32'd0, 32'(halt));
    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("timeout: the core never raised halt");
      $display(">>> FAIL");
      $fatal(1, "halt timeout");
    end else begin
      // core must stay parked after ecall
      repeat (64) begin
        @(negedge clk);
        check_equal("halt held", 32'd1, 32'(halt));
        check_equal("no request after halt", 32'd0, 32'(bus_req));
      end
      check_equal("access count", 32'(exp_addr.size()), 32'(access_idx));
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
